//--- design/mem_pipe_pkg.sv
/* Common widths, memory op encoding, PTE layout and op decode helpers.
   Imported by the memory pipe, its TLB, walker and data memory. */
package mem_pipe_pkg;

  localparam int dword_width_gp       = 64;
  localparam int vaddr_width_gp       = 16;
  localparam int paddr_width_gp       = 14;
  localparam int page_offset_width_gp = 8;
  localparam int vtag_width_gp        = 8;
  localparam int ptag_width_gp        = 6;

  typedef enum logic [3:0] {
    e_lb, e_lbu, e_lh, e_lhu, e_lw, e_lwu, e_ld,
    e_sb, e_sh, e_sw, e_sd,
    e_flw, e_fld, e_fsw, e_fsd
  } mem_op_e;

  // Sv39-style leaf entry, only the low ppn bits are meaningful here
  typedef struct packed {
    logic [53:0] ppn;
    logic [1:0]  rsw;
    logic        d;
    logic        a;
    logic        g;
    logic        u;
    logic        x;
    logic        w;
    logic        r;
    logic        v;
  } pte_s;

  function automatic logic [3:0] op_size_bytes(mem_op_e op);
    case (op)
      e_lb, e_lbu, e_sb:               return 4'd1;
      e_lh, e_lhu, e_sh:               return 4'd2;
      e_lw, e_lwu, e_sw, e_flw, e_fsw: return 4'd4;
      default:                         return 4'd8;
    endcase
  endfunction

  function automatic logic op_is_load(mem_op_e op);
    return op inside {e_lb, e_lbu, e_lh, e_lhu, e_lw, e_lwu, e_ld, e_flw, e_fld};
  endfunction

  function automatic logic op_is_store(mem_op_e op);
    return op inside {e_sb, e_sh, e_sw, e_sd, e_fsw, e_fsd};
  endfunction

  function automatic logic op_is_float(mem_op_e op);
    return op inside {e_flw, e_fld, e_fsw, e_fsd};
  endfunction

endpackage

//--- design/dtlb.sv
/* Fully associative data TLB with bare-mode passthrough and fault checks.
   Lookup is combinational, fills come from the page-table walker. */
`timescale 1ns/1ps

module dtlb
  import mem_pipe_pkg::*;
#(
  parameter int tlb_els_p = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      sfence_i,
  input  logic                      w_v_i,
  input  logic [vtag_width_gp-1:0]  w_vtag_i,
  input  pte_s                      w_pte_i,
  input  logic                      r_v_i,
  input  logic [vaddr_width_gp-1:0] r_vaddr_i,
  input  logic                      r_load_i,
  input  logic                      r_store_i,
  input  logic                      trans_en_i,
  input  logic                      priv_user_i,
  output logic [ptag_width_gp-1:0]  r_ptag_o,
  output logic                      r_miss_o,
  output logic                      r_access_fault_o,
  output logic                      r_page_fault_o
);

  localparam int ptr_width_lp = (tlb_els_p > 1) ? $clog2(tlb_els_p) : 1;

  logic [tlb_els_p-1:0]     v_r;
  logic [vtag_width_gp-1:0] tag_r [tlb_els_p];
  logic [ptag_width_gp-1:0] ppn_r [tlb_els_p];
  logic [tlb_els_p-1:0]     perm_r_r;
  logic [tlb_els_p-1:0]     perm_w_r;
  logic [tlb_els_p-1:0]     perm_u_r;
  logic [ptr_width_lp-1:0]  rr_r;

  logic [vtag_width_gp-1:0] r_vtag;
  logic                     hit;
  logic [ptag_width_gp-1:0] hit_ppn;
  logic                     hit_r;
  logic                     hit_w;
  logic                     hit_u;
  logic                     perm_fail;
  logic                     w_hit;
  logic [ptr_width_lp-1:0]  w_idx;

  assign r_vtag = r_vaddr_i[page_offset_width_gp +: vtag_width_gp];

  always_comb begin
    hit     = 1'b0;
    hit_ppn = '0;
    hit_r   = 1'b0;
    hit_w   = 1'b0;
    hit_u   = 1'b0;
    for (int i = 0; i < tlb_els_p; i++) begin
      if (v_r[i] && (tag_r[i] == r_vtag)) begin
        hit     = 1'b1;
        hit_ppn = ppn_r[i];
        hit_r   = perm_r_r[i];
        hit_w   = perm_w_r[i];
        hit_u   = perm_u_r[i];
      end
    end
  end

  // A refill of a page already present reuses its slot
  always_comb begin
    w_hit = 1'b0;
    w_idx = rr_r;
    for (int i = 0; i < tlb_els_p; i++) begin
      if (v_r[i] && (tag_r[i] == w_vtag_i)) begin
        w_hit = 1'b1;
        w_idx = ptr_width_lp'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || sfence_i) begin
      v_r  <= '0;
      rr_r <= '0;
    end else if (w_v_i) begin
      v_r[w_idx] <= 1'b1;
      if (!w_hit) begin
        rr_r <= (rr_r == ptr_width_lp'(tlb_els_p - 1)) ? '0 : rr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_v_i) begin
      tag_r[w_idx]    <= w_vtag_i;
      ppn_r[w_idx]    <= w_pte_i.ppn[ptag_width_gp-1:0];
      perm_r_r[w_idx] <= w_pte_i.r;
      perm_w_r[w_idx] <= w_pte_i.w;
      perm_u_r[w_idx] <= w_pte_i.u;
    end
  end

  assign perm_fail = (r_load_i && !hit_r) || (r_store_i && !hit_w) || (priv_user_i && !hit_u);

  // Bare mode maps the low address bits straight through
  assign r_ptag_o = trans_en_i ? hit_ppn
                               : r_vaddr_i[paddr_width_gp-1:page_offset_width_gp];
  assign r_access_fault_o = r_v_i && !trans_en_i
                          && (|r_vaddr_i[vaddr_width_gp-1:paddr_width_gp]);
  assign r_miss_o         = r_v_i && trans_en_i && !hit;
  assign r_page_fault_o   = r_v_i && trans_en_i && hit && perm_fail;

endmodule

//--- design/ptw.sv
/* One-level page-table walker. Reads a single PTE through the shared
   memory port and writes it into the data TLB when it is valid. */
`timescale 1ns/1ps

module ptw
  import mem_pipe_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      miss_v_i,
  input  logic [vtag_width_gp-1:0]  miss_vtag_i,
  input  logic [ptag_width_gp-1:0]  base_ppn_i,
  input  logic [dword_width_gp-1:0] mem_data_i,
  output logic                      busy_o,
  output logic                      mem_v_o,
  output logic [paddr_width_gp-1:0] mem_addr_o,
  output logic                      fill_v_o,
  output logic [vtag_width_gp-1:0]  fill_vtag_o,
  output pte_s                      fill_pte_o
);

  typedef enum logic [1:0] {
    e_idle,
    e_req,
    e_read,
    e_fill
  } state_e;

  state_e                   state_r;
  state_e                   state_n;
  logic [vtag_width_gp-1:0] vtag_r;
  pte_s                     pte_r;

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle: begin
        if (miss_v_i) begin
          state_n = e_req;
        end
      end
      e_req:   state_n = e_read;
      e_read:  state_n = e_fill;
      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= e_idle;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == e_idle) && miss_v_i) begin
      vtag_r <= miss_vtag_i;
    end
    // Memory answers one cycle after the request
    if (state_r == e_read) begin
      pte_r <= mem_data_i;
    end
  end

  // PTE byte address is base page plus vtag times 8
  assign mem_addr_o = {base_ppn_i, {page_offset_width_gp{1'b0}}}
                    + paddr_width_gp'({vtag_r, 3'b000});

  assign busy_o      = (state_r != e_idle);
  assign mem_v_o     = (state_r == e_req);
  assign fill_v_o    = (state_r == e_fill) && pte_r.v;
  assign fill_vtag_o = vtag_r;
  assign fill_pte_o  = pte_r;

endmodule

//--- design/data_mem.sv
/* Physically addressed dword RAM standing in for the data cache.
   One read or write per cycle, read data appears on the next cycle. */
`timescale 1ns/1ps

module data_mem
  import mem_pipe_pkg::*;
#(
  parameter int mem_words_p = 2048
) (
  input  logic                           clk_i,
  input  logic                           v_i,
  input  logic                           w_i,
  input  logic [$clog2(mem_words_p)-1:0] addr_i,
  input  logic [7:0]                     wmask_i,
  input  logic [dword_width_gp-1:0]      wdata_i,
  output logic [dword_width_gp-1:0]      rdata_o
);

  logic [dword_width_gp-1:0] mem_r [mem_words_p];

  initial begin
    for (int i = 0; i < mem_words_p; i++) begin
      mem_r[i] = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && w_i) begin
      for (int b = 0; b < 8; b++) begin
        if (wmask_i[b]) begin
          mem_r[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
    // Holds the last read word while idle
    if (v_i && !w_i) begin
      rdata_o <= mem_r[addr_i];
    end
  end

endmodule

//--- design/pipe_mem.sv
/* Memory-instruction pipe: effective address, TLB check, memory port arbitration,
   load shaping and exception reporting. Early integer data in cycle 1, float in 2. */
`timescale 1ns/1ps

module pipe_mem
  import mem_pipe_pkg::*;
#(
  parameter int tlb_els_p   = 4,
  parameter int mem_words_p = 2048
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      reservation_v_i,
  input  mem_op_e                   op_i,
  input  logic [dword_width_gp-1:0] rs1_i,
  input  logic [dword_width_gp-1:0] rs2_i,
  input  logic [dword_width_gp-1:0] imm_i,
  input  logic                      trans_en_i,
  input  logic                      priv_user_i,
  input  logic [ptag_width_gp-1:0]  base_ppn_i,
  input  logic                      sfence_i,
  input  logic                      ptw_miss_v_i,
  input  logic [vtag_width_gp-1:0]  ptw_miss_vtag_i,
  output logic                      ready_o,
  output logic                      ptw_busy_o,
  output logic                      tlb_load_miss_v_o,
  output logic                      tlb_store_miss_v_o,
  output logic                      load_misaligned_v_o,
  output logic                      store_misaligned_v_o,
  output logic                      load_access_fault_v_o,
  output logic                      store_access_fault_v_o,
  output logic                      load_page_fault_v_o,
  output logic                      store_page_fault_v_o,
  output logic                      early_v_o,
  output logic [dword_width_gp-1:0] early_data_o,
  output logic                      final_v_o,
  output logic [dword_width_gp-1:0] final_data_o
);

  localparam int mem_addr_width_lp = $clog2(mem_words_p);

  logic [vaddr_width_gp-1:0] eaddr;
  logic                      pipe_v;
  logic                      is_load;
  logic                      is_store;
  logic                      is_float;
  logic [3:0]                size;
  logic                      misaligned;
  logic [ptag_width_gp-1:0]  dtlb_ptag;
  logic                      dtlb_miss;
  logic                      dtlb_access_fault;
  logic                      dtlb_page_fault;
  logic                      mis_v;
  logic                      acc_v;
  logic                      miss_v;
  logic                      pf_v;
  logic                      ok_v;
  logic [paddr_width_gp-1:0] paddr;
  logic [7:0]                size_mask;

  logic                      ptw_busy;
  logic                      ptw_mem_v;
  logic [paddr_width_gp-1:0] ptw_mem_addr;
  logic                      ptw_fill_v;
  logic [vtag_width_gp-1:0]  ptw_fill_vtag;
  pte_s                      ptw_fill_pte;

  logic                         mem_v;
  logic                         mem_w;
  logic [mem_addr_width_lp-1:0] mem_addr;
  logic [7:0]                   mem_wmask;
  logic [dword_width_gp-1:0]    mem_wdata;
  logic [dword_width_gp-1:0]    mem_rdata;

  mem_op_e                   op_r;
  logic [2:0]                offset_r;
  logic                      final_v1_r;
  logic [dword_width_gp-1:0] load_shifted;
  logic [dword_width_gp-1:0] load_data;

  assign eaddr    = vaddr_width_gp'(rs1_i + imm_i);
  assign pipe_v   = reservation_v_i && !ptw_busy;
  assign is_load  = op_is_load(op_i);
  assign is_store = op_is_store(op_i);
  assign is_float = op_is_float(op_i);
  assign size     = op_size_bytes(op_i);

  assign misaligned = |(eaddr[2:0] & (size[2:0] - 3'd1));

  dtlb #(
    .tlb_els_p(tlb_els_p)
  ) dtlb (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .sfence_i(sfence_i),
    .w_v_i(ptw_fill_v),
    .w_vtag_i(ptw_fill_vtag),
    .w_pte_i(ptw_fill_pte),
    .r_v_i(pipe_v),
    .r_vaddr_i(eaddr),
    .r_load_i(is_load),
    .r_store_i(is_store),
    .trans_en_i(trans_en_i),
    .priv_user_i(priv_user_i),
    .r_ptag_o(dtlb_ptag),
    .r_miss_o(dtlb_miss),
    .r_access_fault_o(dtlb_access_fault),
    .r_page_fault_o(dtlb_page_fault)
  );

  ptw ptw (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .miss_v_i(ptw_miss_v_i),
    .miss_vtag_i(ptw_miss_vtag_i),
    .base_ppn_i(base_ppn_i),
    .mem_data_i(mem_rdata),
    .busy_o(ptw_busy),
    .mem_v_o(ptw_mem_v),
    .mem_addr_o(ptw_mem_addr),
    .fill_v_o(ptw_fill_v),
    .fill_vtag_o(ptw_fill_vtag),
    .fill_pte_o(ptw_fill_pte)
  );

  // Misaligned, then access fault, then miss, then page fault
  assign mis_v  = pipe_v && misaligned;
  assign acc_v  = pipe_v && !misaligned && dtlb_access_fault;
  assign miss_v = pipe_v && !misaligned && !dtlb_access_fault && dtlb_miss;
  assign pf_v   = pipe_v && !misaligned && !dtlb_access_fault && !dtlb_miss && dtlb_page_fault;
  assign ok_v   = pipe_v && !mis_v && !acc_v && !miss_v && !pf_v;

  assign paddr = {dtlb_ptag, eaddr[page_offset_width_gp-1:0]};

  always_comb begin
    case (size)
      4'd1:    size_mask = 8'h01;
      4'd2:    size_mask = 8'h03;
      4'd4:    size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  // Walker owns the port for the whole walk
  always_comb begin
    if (ptw_busy) begin
      mem_v     = ptw_mem_v;
      mem_w     = 1'b0;
      mem_addr  = ptw_mem_addr[3 +: mem_addr_width_lp];
      mem_wmask = '0;
      mem_wdata = '0;
    end else begin
      mem_v     = ok_v;
      mem_w     = is_store;
      mem_addr  = paddr[3 +: mem_addr_width_lp];
      mem_wmask = size_mask << eaddr[2:0];
      mem_wdata = rs2_i << {eaddr[2:0], 3'b000};
    end
  end

  data_mem #(
    .mem_words_p(mem_words_p)
  ) data_mem (
    .clk_i(clk_i),
    .v_i(mem_v),
    .w_i(mem_w),
    .addr_i(mem_addr),
    .wmask_i(mem_wmask),
    .wdata_i(mem_wdata),
    .rdata_o(mem_rdata)
  );

  always_ff @(posedge clk_i) begin
    if (pipe_v) begin
      op_r     <= op_i;
      offset_r <= eaddr[2:0];
    end
    if (final_v1_r) begin
      final_data_o <= load_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      early_v_o              <= 1'b0;
      final_v1_r             <= 1'b0;
      final_v_o              <= 1'b0;
      tlb_load_miss_v_o      <= 1'b0;
      tlb_store_miss_v_o     <= 1'b0;
      load_misaligned_v_o    <= 1'b0;
      store_misaligned_v_o   <= 1'b0;
      load_access_fault_v_o  <= 1'b0;
      store_access_fault_v_o <= 1'b0;
      load_page_fault_v_o    <= 1'b0;
      store_page_fault_v_o   <= 1'b0;
    end else begin
      early_v_o              <= ok_v && is_load && !is_float;
      final_v1_r             <= ok_v && is_load && is_float;
      final_v_o              <= final_v1_r;
      tlb_load_miss_v_o      <= miss_v && is_load;
      tlb_store_miss_v_o     <= miss_v && is_store;
      load_misaligned_v_o    <= mis_v && is_load;
      store_misaligned_v_o   <= mis_v && is_store;
      load_access_fault_v_o  <= acc_v && is_load;
      store_access_fault_v_o <= acc_v && is_store;
      load_page_fault_v_o    <= pf_v && is_load;
      store_page_fault_v_o   <= pf_v && is_store;
    end
  end

  assign load_shifted = mem_rdata >> {offset_r, 3'b000};

  always_comb begin
    case (op_r)
      e_lb:    load_data = {{56{load_shifted[7]}}, load_shifted[7:0]};
      e_lbu:   load_data = {56'd0, load_shifted[7:0]};
      e_lh:    load_data = {{48{load_shifted[15]}}, load_shifted[15:0]};
      e_lhu:   load_data = {48'd0, load_shifted[15:0]};
      e_lw:    load_data = {{32{load_shifted[31]}}, load_shifted[31:0]};
      e_lwu:   load_data = {32'd0, load_shifted[31:0]};
      // NaN-boxed single
      e_flw:   load_data = {32'hffff_ffff, load_shifted[31:0]};
      default: load_data = load_shifted;
    endcase
  end

  assign early_data_o = load_data;
  assign ready_o      = !ptw_busy;
  assign ptw_busy_o   = ptw_busy;

endmodule

//--- testbench/pipe_mem_properties.sv
/* Concurrent timing and dispatch checks for the memory pipe.
   Bound into pipe_mem by the testbench. */
`timescale 1ns/1ps

module pipe_mem_properties
  import mem_pipe_pkg::*;
(
  input logic    clk_i,
  input logic    rst_i,
  input logic    reservation_v_i,
  input mem_op_e op_i,
  input logic    ready_o,
  input logic    early_v_o,
  input logic    final_v_o,
  input logic    [7:0] exc_i
);

  int fail_count = 0;

  logic int_load_disp;
  logic flt_load_disp;
  logic exc_any;

  assign int_load_disp = reservation_v_i && ready_o
                       && (op_i inside {e_lb, e_lbu, e_lh, e_lhu, e_lw, e_lwu, e_ld});
  assign flt_load_disp = reservation_v_i && ready_o && (op_i inside {e_flw, e_fld});
  assign exc_any       = |exc_i;

  ready_after_reset: assert property (@(posedge clk_i) $fell(rst_i) |-> ready_o)
    else begin
      fail_count++;
      $error("ready_o low after reset");
    end

  // Integer data one cycle after dispatch unless the access faulted
  early_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    early_v_o == ($past(int_load_disp) && !exc_any))
    else begin
      fail_count++;
      $error("early_v_o out of step with integer load dispatch");
    end

  final_two_cycles: assert property (@(posedge clk_i) disable iff (rst_i)
    final_v_o == ($past(flt_load_disp, 2) && !$past(exc_any)))
    else begin
      fail_count++;
      $error("final_v_o out of step with float load dispatch");
    end

  dispatch_when_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    reservation_v_i |-> ready_o)
    else begin
      fail_count++;
      $error("dispatch while ready_o low");
    end

  one_exception: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(exc_i))
    else begin
      fail_count++;
      $error("more than one exception flag high");
    end

endmodule

//--- testbench/tb_pipe_mem.sv
/* Testbench for the memory pipe. Drives loads, stores and walks against a byte
   model of physical memory and a small page table. */
`timescale 1ns/1ps

module tb_pipe_mem;
  import mem_pipe_pkg::*;

  localparam logic [7:0] lmiss = 8'h80;
  localparam logic [7:0] smiss = 8'h40;
  localparam logic [7:0] lmis  = 8'h20;
  localparam logic [7:0] smis  = 8'h10;
  localparam logic [7:0] lacc  = 8'h08;
  localparam logic [7:0] sacc  = 8'h04;
  localparam logic [7:0] lpf   = 8'h02;
  localparam logic [7:0] spf   = 8'h01;

  logic clk_i, rst_i, reservation_v_i, trans_en_i, priv_user_i, sfence_i;
  logic ptw_miss_v_i;
  mem_op_e op_i;
  logic [63:0] rs1_i, rs2_i, imm_i;
  logic [5:0] base_ppn_i;
  logic [7:0] ptw_miss_vtag_i;
  logic ready_o, ptw_busy_o, early_v_o, final_v_o;
  logic tlb_load_miss_v_o, tlb_store_miss_v_o, load_misaligned_v_o, store_misaligned_v_o;
  logic load_access_fault_v_o, store_access_fault_v_o;
  logic load_page_fault_v_o, store_page_fault_v_o;
  logic [63:0] early_data_o, final_data_o;
  logic [7:0] exc_flags;

  logic [7:0]  model_mem [16384];
  logic [63:0] rng = 64'd41;
  mem_op_e store_ops [4] = '{e_sb, e_sh, e_sw, e_sd};
  mem_op_e int_loads [7] = '{e_lb, e_lbu, e_lh, e_lhu, e_lw, e_lwu, e_ld};

  assign exc_flags = {tlb_load_miss_v_o, tlb_store_miss_v_o, load_misaligned_v_o,
                      store_misaligned_v_o, load_access_fault_v_o, store_access_fault_v_o,
                      load_page_fault_v_o, store_page_fault_v_o};

  pipe_mem #(.tlb_els_p(4), .mem_words_p(2048)) uut (.*);

  bind pipe_mem pipe_mem_properties props (
    .clk_i(clk_i), .rst_i(rst_i), .reservation_v_i(reservation_v_i), .op_i(op_i),
    .ready_o(ready_o), .early_v_o(early_v_o), .final_v_o(final_v_o),
    .exc_i({tlb_load_miss_v_o, tlb_store_miss_v_o, load_misaligned_v_o,
            store_misaligned_v_o, load_access_fault_v_o, store_access_fault_v_o,
            load_page_fault_v_o, store_page_fault_v_o})
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [63:0] next_random(input logic [63:0] s);
    s ^= s << 13;
    s ^= s >> 7;
    s ^= s << 17;
    return s;
  endfunction

  function automatic int access_bytes(input mem_op_e op);
    case (op)
      e_lb, e_lbu, e_sb:               return 1;
      e_lh, e_lhu, e_sh:               return 2;
      e_lw, e_lwu, e_sw, e_flw, e_fsw: return 4;
      default:                         return 8;
    endcase
  endfunction

  function automatic logic [63:0] model_value(input mem_op_e op, input int unsigned paddr);
    logic [63:0] raw;
    raw = '0;
    for (int i = 0; i < access_bytes(op); i++) begin
      raw[8*i +: 8] = model_mem[paddr + i];
    end
    case (op)
      e_lb:    return {{56{raw[7]}}, raw[7:0]};
      e_lh:    return {{48{raw[15]}}, raw[15:0]};
      e_lw:    return {{32{raw[31]}}, raw[31:0]};
      e_flw:   return {32'hffff_ffff, raw[31:0]};
      default: return raw;
    endcase
  endfunction

  function automatic logic [63:0] make_pte(input logic [5:0] ppn, input logic [7:0] flags);
    return {48'd0, ppn, 2'b00, flags};
  endfunction

  task automatic stop_on_failure();
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic abort_with(input string why);
    $display("%s", why);
    stop_on_failure();
  endtask

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    stop_on_failure();
  endtask

  // Returns at the negative edge of cycle 1
  task automatic issue(input mem_op_e op, input logic [15:0] vaddr, input logic [63:0] data);
    int waited;
    waited = 0;
    while (!ready_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > 20) abort_with("timed out waiting for ready_o before dispatch");
    end
    rng = next_random(rng);
    @(posedge clk_i);
    #1;
    reservation_v_i = 1'b1;
    op_i            = op;
    rs1_i           = rng;
    imm_i           = {48'd0, vaddr} - rng;
    rs2_i           = data;
    @(posedge clk_i);
    #1;
    reservation_v_i = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic store_and_record(input mem_op_e op, input logic [15:0] vaddr,
                                  input int unsigned paddr, input logic [63:0] data);
    issue(op, vaddr, data);
    assert (exc_flags == 8'h00 && !early_v_o)
      else report_mismatch($sformatf("%s at %h flags %b", op.name(), vaddr, exc_flags));
    for (int i = 0; i < access_bytes(op); i++) begin
      model_mem[paddr + i] = data[8*i +: 8];
    end
  endtask

  task automatic load_and_compare(input mem_op_e op, input logic [15:0] vaddr,
                                  input int unsigned paddr);
    logic [63:0] expected;
    expected = model_value(op, paddr);
    issue(op, vaddr, 64'd0);
    assert (exc_flags == 8'h00)
      else report_mismatch($sformatf("%s at %h flags %b", op.name(), vaddr, exc_flags));
    if (op == e_flw || op == e_fld) begin
      assert (!early_v_o) else report_mismatch("early_v_o high for a float load");
      @(negedge clk_i);
      assert (final_v_o && final_data_o == expected)
        else report_mismatch($sformatf("%s at %h got %h want %h", op.name(), vaddr,
                                       final_data_o, expected));
    end else begin
      assert (early_v_o && early_data_o == expected)
        else report_mismatch($sformatf("%s at %h got %h want %h", op.name(), vaddr,
                                       early_data_o, expected));
    end
  endtask

  task automatic expect_fault(input mem_op_e op, input logic [15:0] vaddr,
                              input logic [7:0] mask);
    issue(op, vaddr, 64'hdead_beef_0bad_f00d);
    assert (exc_flags == mask && !early_v_o)
      else report_mismatch($sformatf("%s at %h flags %b want %b", op.name(), vaddr,
                                     exc_flags, mask));
    @(negedge clk_i);
    assert (!final_v_o) else report_mismatch("final_v_o high after a fault");
  endtask

  task automatic walk(input logic [7:0] vtag);
    int busy_cycles;
    busy_cycles = 0;
    @(posedge clk_i);
    #1;
    ptw_miss_v_i    = 1'b1;
    ptw_miss_vtag_i = vtag;
    @(posedge clk_i);
    #1;
    ptw_miss_v_i = 1'b0;
    @(negedge clk_i);
    while (ptw_busy_o) begin
      assert (!ready_o) else report_mismatch("ready_o high during a walk");
      busy_cycles++;
      if (busy_cycles > 20) abort_with("timed out waiting for the walk to finish");
      @(negedge clk_i);
    end
    assert (busy_cycles == 3 && ready_o)
      else report_mismatch($sformatf("walk busy for %0d cycles", busy_cycles));
  endtask

  task automatic flush_tlb();
    @(posedge clk_i);
    #1;
    sfence_i = 1'b1;
    @(posedge clk_i);
    #1;
    sfence_i = 1'b0;
  endtask

  always @(negedge clk_i) begin
    if (uut.props.fail_count != 0) abort_with("a timing or protocol assertion failed");
  end

  initial begin
    logic [15:0] addr;
    logic [15:0] la;
    mem_op_e sop;
    int n;
    rst_i = 1'b1;
    reservation_v_i = 1'b0;
    op_i = e_lb;
    rs1_i = '0;
    rs2_i = '0;
    imm_i = '0;
    trans_en_i = 1'b0;
    priv_user_i = 1'b0;
    base_ppn_i = 6'h30;
    sfence_i = 1'b0;
    ptw_miss_v_i = 1'b0;
    ptw_miss_vtag_i = '0;
    for (int i = 0; i < 16384; i++) begin
      model_mem[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // Bare mode, every store width then every load width in the same dword
    for (int k = 0; k < 12; k++) begin
      sop = store_ops[k % 4];
      n = access_bytes(sop);
      rng = next_random(rng);
      addr = {3'b000, rng[12:0]} & ~16'(n - 1);
      rng = next_random(rng);
      store_and_record(sop, addr, addr, rng);
      foreach (int_loads[j]) begin
        rng = next_random(rng);
        la = {addr[15:3], rng[2:0] & ~3'(access_bytes(int_loads[j]) - 1)};
        load_and_compare(int_loads[j], la, la);
      end
    end

    rng = next_random(rng);
    addr = {3'b000, rng[12:3], 3'b000};
    rng = next_random(rng);
    store_and_record(e_fsd, addr, addr, rng);
    load_and_compare(e_fld, addr, addr);
    load_and_compare(e_flw, addr + 16'd4, addr + 16'd4);
    rng = next_random(rng);
    store_and_record(e_fsw, addr, addr, rng);
    load_and_compare(e_flw, addr, addr);
    load_and_compare(e_ld, addr, addr);

    rng = next_random(rng);
    store_and_record(e_sd, 16'h0100, 32'h100, rng);
    expect_fault(e_lh, 16'h0101, lmis);
    expect_fault(e_lw, 16'h0102, lmis);
    expect_fault(e_ld, 16'h0104, lmis);
    expect_fault(e_fld, 16'h0104, lmis);
    expect_fault(e_sh, 16'h0103, smis);
    expect_fault(e_sw, 16'h0106, smis);
    expect_fault(e_sd, 16'h0101, smis);
    load_and_compare(e_ld, 16'h0100, 32'h100);

    // Bits above the physical width
    expect_fault(e_ld, 16'h4108, lacc);
    expect_fault(e_sd, 16'hc100, sacc);
    expect_fault(e_lw, 16'h4101, lmis);
    load_and_compare(e_ld, 16'h0100, 32'h100);

    store_and_record(e_sd, 16'h32d0, 32'h32d0, make_pte(6'h25, 8'h17));
    store_and_record(e_sd, 16'h3358, 32'h3358, make_pte(6'h26, 8'h13));
    store_and_record(e_sd, 16'h33e0, 32'h33e0, make_pte(6'h27, 8'h07));
    store_and_record(e_sd, 16'h3088, 32'h3088, 64'd0);
    rng = next_random(rng);
    store_and_record(e_sd, 16'h2510, 32'h2510, rng);
    rng = next_random(rng);
    store_and_record(e_sd, 16'h2620, 32'h2620, rng);
    @(posedge clk_i);
    #1;
    trans_en_i = 1'b1;
    flush_tlb();

    expect_fault(e_ld, 16'h5a10, lmiss);
    walk(8'h5a);
    load_and_compare(e_ld, 16'h5a10, 32'h2510);
    load_and_compare(e_lh, 16'h5a16, 32'h2516);
    rng = next_random(rng);
    store_and_record(e_sw, 16'h5a1c, 32'h251c, rng);
    load_and_compare(e_lwu, 16'h5a1c, 32'h251c);
    load_and_compare(e_fld, 16'h5a10, 32'h2510);

    expect_fault(e_sd, 16'h6b20, smiss);
    walk(8'h6b);
    load_and_compare(e_lw, 16'h6b20, 32'h2620);
    expect_fault(e_sd, 16'h6b20, spf);
    load_and_compare(e_ld, 16'h6b20, 32'h2620);

    @(posedge clk_i);
    #1;
    priv_user_i = 1'b1;
    expect_fault(e_ld, 16'h7c00, lmiss);
    walk(8'h7c);
    expect_fault(e_ld, 16'h7c00, lpf);
    expect_fault(e_flw, 16'h7c04, lpf);
    expect_fault(e_lw, 16'h7c02, lmis);
    load_and_compare(e_lbu, 16'h5a10, 32'h2510);
    flush_tlb();
    expect_fault(e_ld, 16'h7c00, lmiss);
    expect_fault(e_sd, 16'h6b20, smiss);

    // Invalid PTE leaves the TLB empty for that page
    walk(8'h11);
    expect_fault(e_lb, 16'h1100, lmiss);

    repeat (3) @(negedge clk_i);
    if (uut.props.fail_count != 0) begin
      abort_with("a timing or protocol assertion failed");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

//--- files.f
design/mem_pipe_pkg.sv
design/dtlb.sv
design/ptw.sv
design/data_mem.sv
design/pipe_mem.sv
testbench/pipe_mem_properties.sv
testbench/tb_pipe_mem.sv

//--- Makefile
TOP := tb_pipe_mem

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100

obj_dir/V$(TOP): files.f $(shell cat files.f)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir
